/* build.f */
+incdir+source
source/hazard_pkg.sv
source/instr_fields.sv
source/instr_history.sv
source/load_use_stall.sv
source/forward_select.sv
source/hazard_unit.sv
verif/hazard_unit_checker.sv
verif/hazard_unit_tb.sv

/* verif/hazard_unit_tb.sv */
/*
 * Testbench for the hazard unit
 * Hand-computed stimulus table, random non-load filler, timeout
 */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_consts.svh"

module hazard_unit_tb import hazard_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int FILLER_LEN = 40;
	localparam int MARGIN = 50;

	// Short select names for the table
	localparam fwd_sel_t RF = FWD_REGFILE;
	localparam fwd_sel_t EX = FWD_EX;
	localparam fwd_sel_t MM = FWD_MEM;

	logic clk;
	logic rst_n;
	instr_t instr;
	logic stall;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	// One entry per cycle spent in ID
	instr_t row_instr[$];
	logic row_stall[$];
	fwd_sel_t row_fwd_a[$];
	fwd_sel_t row_fwd_b[$];
	logic row_chk_fwd[$];

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;

	hazard_unit uut (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.stall(stall),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	bind hazard_unit hazard_unit_checker hazard_chk (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog on the total cycle count
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic instr_t make_word(opcode_t op, int d, int s1, int s2);
		instr_t w;
		w[`WISC_OPCODE_MSB:`WISC_OPCODE_LSB] = op;
		w[`WISC_DEST_MSB:`WISC_DEST_LSB] = reg_addr_t'(d);
		w[`WISC_SRC1_MSB:`WISC_SRC1_LSB] = reg_addr_t'(s1);
		w[`WISC_SRC2_MSB:`WISC_SRC2_LSB] = reg_addr_t'(s2);
		return w;
	endfunction

	task automatic add_row(input instr_t w, input logic s, input fwd_sel_t a,
			input fwd_sel_t b, input logic chk_fwd = 1'b1);
		row_instr.push_back(w);
		row_stall.push_back(s);
		row_fwd_a.push_back(a);
		row_fwd_b.push_back(b);
		row_chk_fwd.push_back(chk_fwd);
	endtask

	task automatic build_table();
		opcode_t arith_ops[8];
		instr_t w;
		int j;
		arith_ops = '{`OP_ADD, `OP_ADDZ, `OP_SUB, `OP_AND, `OP_NOR, `OP_SLL, `OP_SRL, `OP_SRA};
		// r1 consumed from EX, then from MEM
		add_row(make_word(`OP_ADD, 1, 2, 3), 1'b0, RF, RF);
		add_row(make_word(`OP_ADD, 4, 1, 1), 1'b0, EX, EX);
		add_row(make_word(`OP_SUB, 5, 2, 1), 1'b0, RF, MM);
		// Two writers of r6, youngest wins
		add_row(make_word(`OP_ADD, 6, 7, 7), 1'b0, RF, RF);
		add_row(make_word(`OP_AND, 6, 1, 2), 1'b0, RF, RF);
		add_row(make_word(`OP_NOR, 8, 6, 6), 1'b0, EX, EX);
		// Load-use on an ALU source, held consumer sees MEM
		add_row(make_word(`OP_LW, 3, 2, 4), 1'b0, RF, RF);
		add_row(make_word(`OP_ADD, 9, 3, 1), 1'b1, EX, RF);
		add_row(make_word(`OP_ADD, 9, 3, 1), 1'b0, MM, RF);
		// Shift source
		add_row(make_word(`OP_LW, 3, 2, 0), 1'b0, RF, RF);
		add_row(make_word(`OP_SLL, 10, 3, 2), 1'b1, EX, RF);
		add_row(make_word(`OP_SLL, 10, 3, 2), 1'b0, MM, RF);
		// Store data in the destination field
		add_row(make_word(`OP_LW, 4, 2, 1), 1'b0, RF, RF);
		add_row(make_word(`OP_SW, 4, 5, 2), 1'b1, RF, EX);
		add_row(make_word(`OP_SW, 4, 5, 2), 1'b0, RF, MM);
		// LHB reads its own destination
		add_row(make_word(`OP_LW, 7, 1, 0), 1'b0, RF, RF);
		add_row(make_word(`OP_LHB, 7, 1, 2), 1'b1, EX, RF);
		add_row(make_word(`OP_LHB, 7, 1, 2), 1'b0, MM, RF);
		// r0 never written, not even by a load
		add_row(make_word(`OP_ADD, 0, 1, 2), 1'b0, RF, RF);
		add_row(make_word(`OP_ADD, 11, 0, 0), 1'b0, RF, RF);
		add_row(make_word(`OP_LW, 0, 1, 0), 1'b0, RF, RF);
		add_row(make_word(`OP_ADD, 12, 0, 0), 1'b0, RF, RF);
		// Load then unrelated registers, then non-readers
		add_row(make_word(`OP_LW, 5, 1, 0), 1'b0, RF, RF);
		add_row(make_word(`OP_ADD, 13, 6, 7), 1'b0, RF, RF);
		add_row(make_word(`OP_B, 0, 5, 5), 1'b0, RF, RF);
		add_row(make_word(`OP_JAL, 5, 13, 13), 1'b0, RF, RF);
		// JR picks up the link register from EX
		add_row(make_word(`OP_JR, 0, 15, 0), 1'b0, EX, RF);
		add_row(make_word(`OP_HLT, 5, 15, 5), 1'b0, RF, RF);
		// Random arithmetic stream, only stall is checked
		for (j = 0; j < FILLER_LEN; j++) begin
			w = instr_t'($urandom);
			w[`WISC_OPCODE_MSB:`WISC_OPCODE_LSB] = arith_ops[$urandom % 8];
			add_row(w, 1'b0, RF, RF, 1'b0);
		end
	endtask

	task automatic check_outputs(input int idx, input logic exp_stall, input fwd_sel_t exp_a,
			input fwd_sel_t exp_b, input logic chk_fwd);
		checks++;
		assert (stall === exp_stall) else begin
			$display("Error stall row %0d: expected %h, got %h", idx, exp_stall, stall);
			errors++;
		end
		if (chk_fwd) begin
			assert (fwd_a === exp_a) else begin
				$display("Error fwd_a row %0d: expected %h, got %h", idx, exp_a, fwd_a);
				errors++;
			end
			assert (fwd_b === exp_b) else begin
				$display("Error fwd_b row %0d: expected %h, got %h", idx, exp_b, fwd_b);
				errors++;
			end
		end
	endtask

	initial begin
		int n;
		int i;
		int chk_fails;
		rst_n = 1'b0;
		instr = '0;
		void'($urandom(32'h1e8e_b908));
		build_table();
		n = row_instr.size();
		cycle_limit = RESET_CYCLES + n + MARGIN;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		instr <= row_instr[0];
		// Only reset bubbles in the pipeline
		@(negedge clk);
		check_outputs(-1, 1'b0, RF, RF, 1'b1);
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			// A stalled entry is presented again
			if (row_stall[i])
				instr <= row_instr[i];
			else if (i + 1 < n)
				instr <= row_instr[i + 1];
			else
				instr <= make_word(`OP_HLT, 0, 0, 0);
			@(negedge clk);
			check_outputs(i, row_stall[i], row_fwd_a[i], row_fwd_b[i], row_chk_fwd[i]);
		end
		chk_fails = uut.hazard_chk.fail_count;
		$display("Done: %0d checks, %0d value errors, %0d assertion failures",
			checks, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/hazard_unit_checker.sv */
/*
 * Concurrent assertions on the hazard unit outputs
 * Single-cycle stall, quiet first cycle after reset, legal bypass selects
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit_checker import hazard_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic stall,
	input wire fwd_sel_t fwd_a,
	input wire fwd_sel_t fwd_b
);

	// Number of assertion failures so far
	int fail_count = 0;

	// Load has reached MEM one cycle after the stall, so no second stall
	stall_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> !stall
	) else begin
		fail_count = fail_count + 1;
		$error("stall high on two consecutive cycles");
	end

	// FSM start state keeps stall low right after reset
	stall_after_reset: assert property (
		@(posedge clk)
		$rose(rst_n) |-> !stall
	) else begin
		fail_count = fail_count + 1;
		$error("stall high in the first cycle after reset");
	end

	// Encoding 2'b11 is unused
	fwd_a_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		fwd_a inside {FWD_REGFILE, FWD_EX, FWD_MEM}
	) else begin
		fail_count = fail_count + 1;
		$error("fwd_a holds an illegal select %h", fwd_a);
	end

	fwd_b_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		fwd_b inside {FWD_REGFILE, FWD_EX, FWD_MEM}
	) else begin
		fail_count = fail_count + 1;
		$error("fwd_b holds an illegal select %h", fwd_b);
	end

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
/*
 * Hazard unit top level
 * Stage history, field decoders, load-use stall and bypass selection
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import hazard_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire instr_t instr,
	output logic stall,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);

	// Stage registers
	instr_t id_instr;
	instr_t ex_instr;
	instr_t mem_instr;
	logic id_valid;
	logic ex_valid;
	logic mem_valid;

	// Decoded ID operands
	reg_addr_t id_src_a;
	reg_addr_t id_src_b;
	logic id_reads_a;
	logic id_reads_b;

	// Decoded producers
	reg_addr_t ex_dest;
	logic ex_writes;
	logic ex_is_load;
	reg_addr_t mem_dest;
	logic mem_writes;

	instr_history history (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.stall(stall),
		.id_instr(id_instr),
		.ex_instr(ex_instr),
		.mem_instr(mem_instr),
		.id_valid(id_valid),
		.ex_valid(ex_valid),
		.mem_valid(mem_valid)
	);

	// Consumer side, only the reads matter
	instr_fields id_fields (
		.instr(id_instr),
		.opcode(),
		.src_a(id_src_a),
		.src_b(id_src_b),
		.dest(),
		.reads_a(id_reads_a),
		.reads_b(id_reads_b),
		.writes_dest(),
		.is_load()
	);

	// Producer sides, only the writes matter
	instr_fields ex_fields (
		.instr(ex_instr),
		.opcode(),
		.src_a(),
		.src_b(),
		.dest(ex_dest),
		.reads_a(),
		.reads_b(),
		.writes_dest(ex_writes),
		.is_load(ex_is_load)
	);

	instr_fields mem_fields (
		.instr(mem_instr),
		.opcode(),
		.src_a(),
		.src_b(),
		.dest(mem_dest),
		.reads_a(),
		.reads_b(),
		.writes_dest(mem_writes),
		.is_load()
	);

	load_use_stall stall_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.id_valid(id_valid),
		.id_reads_a(id_reads_a),
		.id_reads_b(id_reads_b),
		.id_src_a(id_src_a),
		.id_src_b(id_src_b),
		.ex_valid(ex_valid),
		.ex_is_load(ex_is_load),
		.ex_writes(ex_writes),
		.ex_dest(ex_dest),
		.stall(stall)
	);

	forward_select fwd (
		.id_valid(id_valid),
		.id_reads_a(id_reads_a),
		.id_reads_b(id_reads_b),
		.id_src_a(id_src_a),
		.id_src_b(id_src_b),
		.ex_valid(ex_valid),
		.ex_writes(ex_writes),
		.ex_dest(ex_dest),
		.mem_valid(mem_valid),
		.mem_writes(mem_writes),
		.mem_dest(mem_dest),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

endmodule

`default_nettype wire

/* source/forward_select.sv */
/*
 * Operand bypass selection
 * Picks register file, EX or MEM result for operands A and B in ID
 */
`timescale 1ns/1ps
`default_nettype none

module forward_select import hazard_pkg::*; (
	input wire logic id_valid,
	input wire logic id_reads_a,
	input wire logic id_reads_b,
	input wire reg_addr_t id_src_a,
	input wire reg_addr_t id_src_b,
	input wire logic ex_valid,
	input wire logic ex_writes,
	input wire reg_addr_t ex_dest,
	input wire logic mem_valid,
	input wire logic mem_writes,
	input wire reg_addr_t mem_dest,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);

	logic ex_live;
	logic mem_live;

	// Older stages that will really write a register
	assign ex_live = ex_valid && ex_writes;
	assign mem_live = mem_valid && mem_writes;

	// Same priority rule for both operands
	function automatic fwd_sel_t pick_source(
		input logic reads,
		input reg_addr_t src
	);
		fwd_sel_t sel;
		sel = FWD_REGFILE;
		if (reads && id_valid) begin
			// Youngest producer wins
			if (ex_live && (ex_dest == src))
				sel = FWD_EX;
			else if (mem_live && (mem_dest == src))
				sel = FWD_MEM;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a = pick_source(id_reads_a, id_src_a);
		fwd_b = pick_source(id_reads_b, id_src_b);
	end

endmodule

`default_nettype wire

/* source/load_use_stall.sv */
/*
 * Load-use hazard detection
 * Start, idle and active FSM shaping the hazard into one-cycle stalls
 */
`timescale 1ns/1ps
`default_nettype none

module load_use_stall import hazard_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic id_valid,
	input wire logic id_reads_a,
	input wire logic id_reads_b,
	input wire reg_addr_t id_src_a,
	input wire reg_addr_t id_src_b,
	input wire logic ex_valid,
	input wire logic ex_is_load,
	input wire logic ex_writes,
	input wire reg_addr_t ex_dest,
	output logic stall
);

	stall_state_t state;
	stall_state_t next_state;
	logic ex_load_live;
	logic match_a;
	logic match_b;
	logic hazard;

	// A load in EX whose data is not there until the end of MEM
	assign ex_load_live = ex_valid && ex_is_load && ex_writes;

	// Operand matches against the load destination
	assign match_a = id_reads_a && (id_src_a == ex_dest);
	assign match_b = id_reads_b && (id_src_b == ex_dest);

	assign hazard = id_valid && ex_load_live && (match_a || match_b);

	// State register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= STALL_START;
		else
			state <= next_state;
	end

	// Next state and stall output
	always_comb begin
		next_state = STALL_IDLE;
		stall = 1'b0;
		case (state)
			STALL_START: begin
				// History still empty, nothing to compare
				next_state = STALL_IDLE;
			end
			STALL_IDLE: begin
				stall = hazard;
				if (hazard)
					next_state = STALL_ACTIVE;
			end
			STALL_ACTIVE: begin
				// Load has moved to MEM, the bypass takes over
				next_state = STALL_IDLE;
			end
			default: begin
				next_state = STALL_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/instr_history.sv */
/*
 * Pipeline instruction history
 * ID, EX and MEM instruction registers with one valid bit per stage
 */
`timescale 1ns/1ps
`default_nettype none

module instr_history import hazard_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire instr_t instr,
	input wire logic stall,
	output instr_t id_instr,
	output instr_t ex_instr,
	output instr_t mem_instr,
	output logic id_valid,
	output logic ex_valid,
	output logic mem_valid
);

	// Decode stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_instr <= '0;
			id_valid <= 1'b0;
		end else if (!stall) begin
			id_instr <= instr;
			id_valid <= 1'b1;
		end
		// On stall the upstream repeats the same word, ID just holds
	end

	// Execute stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_instr <= '0;
			ex_valid <= 1'b0;
		end else if (stall) begin
			// Bubble while the consumer waits in ID
			ex_instr <= '0;
			ex_valid <= 1'b0;
		end else begin
			ex_instr <= id_instr;
			ex_valid <= id_valid;
		end
	end

	// Memory stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_instr <= '0;
			mem_valid <= 1'b0;
		end else begin
			// EX always moves on, stall or not
			mem_instr <= ex_instr;
			mem_valid <= ex_valid;
		end
	end

endmodule

`default_nettype wire

/* source/instr_fields.sv */
/*
 * Instruction field decoder
 * Register fields, operand read flags, write flag and load flag
 */
`timescale 1ns/1ps
`default_nettype none

`include "hazard_consts.svh"

module instr_fields import hazard_pkg::*; (
	input wire instr_t instr,
	output opcode_t opcode,
	output reg_addr_t src_a,
	output reg_addr_t src_b,
	output reg_addr_t dest,
	output logic reads_a,
	output logic reads_b,
	output logic writes_dest,
	output logic is_load
);

	reg_addr_t dest_field;
	reg_addr_t src1_field;
	reg_addr_t src2_field;
	logic writes_raw;

	// Raw fields
	assign opcode = instr[`WISC_OPCODE_MSB:`WISC_OPCODE_LSB];
	assign dest_field = instr[`WISC_DEST_MSB:`WISC_DEST_LSB];
	assign src1_field = instr[`WISC_SRC1_MSB:`WISC_SRC1_LSB];
	assign src2_field = instr[`WISC_SRC2_MSB:`WISC_SRC2_LSB];

	always_comb begin
		// Most formats use the plain fields
		src_a = src1_field;
		src_b = src2_field;
		dest = dest_field;
		reads_a = 1'b0;
		reads_b = 1'b0;
		writes_raw = 1'b0;
		case (opcode)
			`OP_ADD, `OP_ADDZ, `OP_SUB, `OP_AND, `OP_NOR: begin
				reads_a = 1'b1;
				reads_b = 1'b1;
				writes_raw = 1'b1;
			end
			`OP_SLL, `OP_SRL, `OP_SRA, `OP_LW: begin
				reads_a = 1'b1;
				writes_raw = 1'b1;
			end
			`OP_SW: begin
				// Store data sits in the destination field
				reads_a = 1'b1;
				reads_b = 1'b1;
				src_b = dest_field;
			end
			`OP_LHB, `OP_LLB: begin
				// Byte loads merge into the old register value
				reads_a = 1'b1;
				src_a = dest_field;
				writes_raw = 1'b1;
			end
			`OP_JR: reads_a = 1'b1;
			`OP_JAL: begin
				dest = `WISC_LINK_REG;
				writes_raw = 1'b1;
			end
			default: begin
				// B and HLT touch no register
			end
		endcase
	end

	// r0 is hardwired, never a hazard source
	assign writes_dest = writes_raw && (dest != '0);
	assign is_load = (opcode == `OP_LW);

endmodule

`default_nettype wire

/* source/hazard_pkg.sv */
/*
 * Shared types for the hazard unit
 * Instruction, opcode and register vectors, stall FSM states, bypass selects
 */
`default_nettype none

`include "hazard_consts.svh"

package hazard_pkg;

	// Full instruction word
	typedef logic [`WISC_INSTR_W-1:0] instr_t;

	// Opcode field
	typedef logic [`WISC_OPCODE_W-1:0] opcode_t;

	// Register number
	typedef logic [`WISC_REG_W-1:0] reg_addr_t;

	// Load-use stall FSM
	typedef enum logic [1:0] {
		// One cycle right after reset
		STALL_START = 2'b00,
		// Watching for a load-use hazard
		STALL_IDLE = 2'b01,
		// Stall just issued, hold it low once
		STALL_ACTIVE = 2'b10
	} stall_state_t;

	// Operand bypass source
	typedef enum logic [1:0] {
		// Value comes from the register file
		FWD_REGFILE = 2'b00,
		// Result of the instruction in execute
		FWD_EX = 2'b01,
		// Result of the instruction in memory
		FWD_MEM = 2'b10
	} fwd_sel_t;

endpackage

`default_nettype wire

/* source/hazard_consts.svh */
/*
 * Instruction format constants for the hazard unit
 * Word, opcode and register widths, field bit positions and opcode values
 */
`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// Widths
`define WISC_INSTR_W 16
`define WISC_REG_W 4
`define WISC_OPCODE_W 4

// Field positions inside an instruction word
`define WISC_OPCODE_MSB 15
`define WISC_OPCODE_LSB 12
`define WISC_DEST_MSB 11
`define WISC_DEST_LSB 8
`define WISC_SRC1_MSB 7
`define WISC_SRC1_LSB 4
`define WISC_SRC2_MSB 3
`define WISC_SRC2_LSB 0

// Opcodes
`define OP_ADD 4'b0000
`define OP_ADDZ 4'b0001
`define OP_SUB 4'b0010
`define OP_AND 4'b0011
`define OP_NOR 4'b0100
`define OP_SLL 4'b0101
`define OP_SRL 4'b0110
`define OP_SRA 4'b0111
`define OP_LW 4'b1000
`define OP_SW 4'b1001
`define OP_LHB 4'b1010
`define OP_LLB 4'b1011
`define OP_B 4'b1100
`define OP_JAL 4'b1101
`define OP_JR 4'b1110
`define OP_HLT 4'b1111

// Link register written by JAL
`define WISC_LINK_REG 4'd15

`endif
